// ==== sim.f ====
+incdir+bench
common/fetch_pkg.sv
imem/bram_ins.sv
imem/ins_mem.sv
design/fetch_unit.sv
design/apb_imem_port.sv
design/fetch_top.sv
bench/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_fetch_top
./obj_dir/Vtb_fetch_top | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi

// ==== bench/tb_fetch_tasks.svh ====
`ifndef TB_FETCH_TASKS_SVH
`define TB_FETCH_TASKS_SVH

// ******************************
// Compare tasks.
// ******************************
task automatic check_word(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                          input string msg);
  if (got !== exp) begin
    $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
    err_count++;
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string msg);
  if (got !== exp) begin
    $display("ERR %0t: %s got %b expected %b", $time, msg, got, exp);
    err_count++;
  end
endtask

task automatic check_fetch(input logic [xlen-1:0] pc_got, input logic [xlen-1:0] instr_got,
                           input logic [xlen-1:0] pc_exp, input logic [xlen-1:0] instr_exp,
                           input string msg);
  if (pc_got !== pc_exp || instr_got !== instr_exp) begin
    $display("ERR %0t: %s got pc %h instr %h expected pc %h instr %h",
             $time, msg, pc_got, instr_got, pc_exp, instr_exp);
    err_count++;
  end
endtask

function automatic logic [xlen-1:0] word_addr(input int idx);
  return idx * 4;
endfunction

task automatic end_test(input string name, input int errs_before);
  tests_run++;
  if (err_count == errs_before) begin
    tests_passed++;
    $display("test %s: ok", name);
  end else begin
    $display("test %s: %0d errors", name, err_count - errs_before);
  end
endtask

// ******************************
// APB master.
// ******************************
task automatic apb_xfer(input logic wr, input logic [xlen-1:0] addr,
                        input logic [xlen-1:0] wdata, input logic [strb_w-1:0] strb,
                        output logic [xlen-1:0] rdata, output logic err);
  int waits;
  waits = 0;
  @(posedge clkb);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= wr;
  paddr   <= addr;
  pwdata  <= wdata;
  pstrb   <= strb;
  @(posedge clkb);
  penable <= 1'b1;
  // Sampled mid-cycle, where outputs are settled.
  do begin
    @(negedge clkb);
    waits++;
  end while (!pready && waits < 8);
  if (!pready) begin
    $display("APB access to %h never returned pready", addr);
    err_count++;
  end
  rdata = prdata;
  err   = pslverr;
  @(posedge clkb);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_write(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                         input logic [strb_w-1:0] strb, output logic err);
  logic [xlen-1:0] rdata;
  apb_xfer(1'b1, addr, data, strb, rdata, err);
endtask

task automatic apb_read(input logic [xlen-1:0] addr, output logic [xlen-1:0] data,
                        output logic err);
  apb_xfer(1'b0, addr, '0, '0, data, err);
endtask

// ******************************
// Fetch consumer.
// ******************************
task automatic step_fetch(input logic stall_nxt, input logic redir_nxt,
                          input logic [xlen-1:0] target_nxt);
  @(negedge clkb);
  // Values seen here are the ones of the cycle ending at the next edge.
  if (hold_seen) begin
    check_bit(fetch_valid, 1'b1, "valid under stall");
    check_fetch(fetch_pc, fetch_instr, held_pc, held_instr, "held word");
  end
  if (redir_seen) begin
    check_bit(fetch_valid, 1'b0, "valid after redirect");
  end
  hold_seen  = fetch_valid && stall && !redirect_valid;
  redir_seen = redirect_valid;
  held_pc    = fetch_pc;
  held_instr = fetch_instr;
  if (redirect_valid) begin
    exp_pc = redirect_pc;
  end else if (fetch_valid && !stall) begin
    check_fetch(fetch_pc, fetch_instr, exp_pc, model[exp_pc[imem_aw+1:2]], "accepted word");
    exp_pc = exp_pc + 4;
    accepted++;
  end
  @(posedge clkb);
  stall          <= stall_nxt;
  redirect_valid <= redir_nxt;
  redirect_pc    <= target_nxt;
endtask

// ******************************
// Directed tests.
// ******************************
task automatic test_reset_state();
  int              errs;
  logic [xlen-1:0] data;
  logic            err;
  errs = err_count;
  repeat (4) @(posedge clkb);
  check_word(fetch_instr, nop_instr, "instr during reset");
  repeat (4) @(posedge clkb);
  rstb <= 1'b0;
  repeat (10) begin
    @(posedge clkb);
    check_bit(fetch_valid, 1'b0, "valid with run clear");
  end
  check_bit(pready, 1'b0, "pready after reset");
  check_bit(pslverr, 1'b0, "pslverr after reset");
  apb_read(ctrl_addr, data, err);
  check_word(data, '0, "control after reset");
  check_bit(err, 1'b0, "pslverr on control read");
  end_test("reset state", errs);
endtask

task automatic test_apb_access();
  int                errs;
  int                idx [8];
  logic [xlen-1:0]   rnd;
  logic [xlen-1:0]   data;
  logic [strb_w-1:0] strb;
  logic              err;
  errs = err_count;
  for (int i = 0; i < 8; i++) begin
    rnd = $random(seed);
    idx[i] = int'(rnd[imem_aw-1:0]);
    model[idx[i]] = $random(seed);
    apb_write(word_addr(idx[i]), model[idx[i]], 4'hf, err);
    check_bit(err, 1'b0, "pslverr on memory write");
  end
  // Partial writes merge into the model lane by lane.
  for (int i = 0; i < 2; i++) begin
    rnd  = $random(seed);
    strb = (i == 0) ? 4'b0101 : 4'b1000;
    apb_write(word_addr(idx[i]), rnd, strb, err);
    for (int b = 0; b < strb_w; b++) begin
      if (strb[b]) begin
        model[idx[i]][8*b +: 8] = rnd[8*b +: 8];
      end
    end
  end
  for (int i = 0; i < 8; i++) begin
    apb_read(word_addr(idx[i]), data, err);
    check_word(data, model[idx[i]], "memory read back");
  end
  apb_write(32'h0000_1000, 32'hdead_beef, 4'hf, err);
  check_bit(err, 1'b1, "pslverr on unmapped write");
  apb_read(32'h0000_1000, data, err);
  check_bit(err, 1'b1, "pslverr on unmapped read");
  check_word(data, '0, "unmapped read data");
  end_test("apb access", errs);
endtask

task automatic test_sequential_fetch();
  int   errs;
  int   goal;
  logic err;
  errs = err_count;
  for (int i = 0; i < 32; i++) begin
    model[i] = $random(seed);
    apb_write(word_addr(i), model[i], 4'hf, err);
  end
  apb_write(ctrl_addr, 32'h1, 4'h1, err);
  goal = accepted + 8;
  while (accepted < goal) begin
    step_fetch(1'b0, 1'b0, '0);
  end
  step_fetch(1'b1, 1'b0, '0);
  end_test("sequential fetch", errs);
endtask

task automatic test_stall();
  int              errs;
  int              goal;
  logic [xlen-1:0] rnd;
  errs = err_count;
  goal = accepted + 12;
  while (accepted < goal) begin
    rnd = $random(seed);
    step_fetch(rnd[0], 1'b0, '0);
  end
  step_fetch(1'b1, 1'b0, '0);
  end_test("stall", errs);
endtask

task automatic test_redirect();
  int              errs;
  int              goal;
  logic [xlen-1:0] rnd;
  errs = err_count;
  rnd = $random(seed);
  // Target within the first 16 loaded words.
  step_fetch(1'b0, 1'b1, word_addr(int'(rnd[3:0])));
  goal = accepted + 8;
  while (accepted < goal) begin
    step_fetch(1'b0, 1'b0, '0);
  end
  step_fetch(1'b1, 1'b0, '0);
  end_test("redirect", errs);
endtask

task automatic test_run_control();
  int              errs;
  int              goal;
  logic [xlen-1:0] data;
  logic            err;
  errs = err_count;
  apb_write(ctrl_addr, 32'h0, 4'h1, err);
  apb_read(ctrl_addr, data, err);
  check_word(data, '0, "control after clear");
  goal = accepted + 1;
  repeat (11) step_fetch(1'b0, 1'b0, '0);
  step_fetch(1'b1, 1'b0, '0);
  check_bit(accepted == goal, 1'b1, "only the presented word drains");
  check_bit(fetch_valid, 1'b0, "valid with run clear");
  apb_write(ctrl_addr, 32'h1, 4'h1, err);
  goal = accepted + 4;
  while (accepted < goal) begin
    step_fetch(1'b0, 1'b0, '0);
  end
  step_fetch(1'b1, 1'b0, '0);
  end_test("run control", errs);
endtask

`endif

// ==== bench/tb_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

  import fetch_pkg::*;

  // ******************************
  // Cycle budgets, one per test.
  // ******************************
  localparam int reset_budget    = 40;
  localparam int apb_budget      = 120;
  localparam int seq_budget      = 180;
  localparam int stall_budget    = 80;
  localparam int redirect_budget = 40;
  localparam int run_budget      = 60;
  localparam int cycle_limit     = 2 * (reset_budget + apb_budget + seq_budget +
                                        stall_budget + redirect_budget + run_budget);

  logic              clkb;
  logic              rstb;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [xlen-1:0]   paddr;
  logic [xlen-1:0]   pwdata;
  logic [strb_w-1:0] pstrb;
  wire  [xlen-1:0]   prdata;
  wire               pready;
  wire               pslverr;
  logic              stall;
  logic              redirect_valid;
  logic [xlen-1:0]   redirect_pc;
  wire               fetch_valid;
  wire  [xlen-1:0]   fetch_pc;
  wire  [xlen-1:0]   fetch_instr;

  // Memory model and fetch tracking.
  logic [xlen-1:0] model [0:imem_depth-1];
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] held_pc;
  logic [xlen-1:0] held_instr;
  logic            hold_seen;
  logic            redir_seen;
  int              accepted;
  int              err_count;
  int              tests_run;
  int              tests_passed;
  int              cycle_count;
  integer          seed;

  fetch_top dut0 (
    .clkb           (clkb),
    .rstb           (rstb),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .pstrb          (pstrb),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr)
  );

  `include "tb_fetch_tasks.svh"

  initial begin
    clkb = 1'b0;
    forever #2 clkb = ~clkb;
  end

  // Run limit.
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clkb);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d cycles", cycle_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    seed = 32'h84ef;
    rstb           <= 1'b1;
    psel           <= 1'b0;
    penable        <= 1'b0;
    pwrite         <= 1'b0;
    paddr          <= '0;
    pwdata         <= '0;
    pstrb          <= '0;
    stall          <= 1'b1;
    redirect_valid <= 1'b0;
    redirect_pc    <= '0;
    exp_pc       = boot_pc;
    hold_seen    = 1'b0;
    redir_seen   = 1'b0;
    accepted     = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_passed = 0;
    test_reset_state();
    test_apb_access();
    test_sequential_fetch();
    test_stall();
    test_redirect();
    test_run_control();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire                          clkb,
  input  wire                          rstb,

  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [fetch_pkg::xlen-1:0]    paddr,
  input  wire [fetch_pkg::xlen-1:0]    pwdata,
  input  wire [fetch_pkg::strb_w-1:0]  pstrb,
  output wire [fetch_pkg::xlen-1:0]    prdata,
  output wire                          pready,
  output wire                          pslverr,

  input  wire                          stall,
  input  wire                          redirect_valid,
  input  wire [fetch_pkg::xlen-1:0]    redirect_pc,
  output wire                          fetch_valid,
  output wire [fetch_pkg::xlen-1:0]    fetch_pc,
  output wire [fetch_pkg::xlen-1:0]    fetch_instr
);

  import fetch_pkg::*;

  // Port A between the APB slave and the RAM.
  wire               ena;
  wire [strb_w-1:0]  wea;
  wire [imem_aw-1:0] addra;
  wire [xlen-1:0]    dina;
  wire [xlen-1:0]    douta;

  // Fetch side.
  wire               run;
  wire [xlen-1:0]    pc;
  wire               enb;
  wire [xlen-1:0]    instruction;

  apb_imem_port apb0 (
    .clkb    (clkb),
    .rstb    (rstb),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ena     (ena),
    .wea     (wea),
    .addra   (addra),
    .dina    (dina),
    .douta   (douta),
    .run     (run)
  );

  ins_mem imem0 (
    .clkb        (clkb),
    .rstb        (rstb),
    .pc          (pc),
    .enb         (enb),
    .instruction (instruction),
    .ena         (ena),
    .wea         (wea),
    .addra       (addra),
    .dina        (dina),
    .douta       (douta)
  );

  fetch_unit fetch0 (
    .clkb           (clkb),
    .rstb           (rstb),
    .run            (run),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pc             (pc),
    .enb            (enb),
    .instruction    (instruction),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr)
  );

endmodule

`default_nettype wire

// ==== design/apb_imem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_imem_port (
  input  wire                           clkb,
  input  wire                           rstb,

  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire [fetch_pkg::xlen-1:0]     paddr,
  input  wire [fetch_pkg::xlen-1:0]     pwdata,
  input  wire [fetch_pkg::strb_w-1:0]   pstrb,
  output logic [fetch_pkg::xlen-1:0]    prdata,
  output logic                          pready,
  output logic                          pslverr,

  output wire                           ena,
  output wire [fetch_pkg::strb_w-1:0]   wea,
  output wire [fetch_pkg::imem_aw-1:0]  addra,
  output wire [fetch_pkg::xlen-1:0]     dina,
  input  wire [fetch_pkg::xlen-1:0]     douta,

  output logic                          run
);

  import fetch_pkg::*;

  logic mem_hit;
  logic ctrl_hit;
  logic first_cycle;

  // ******************************
  // Address decode.
  // ******************************
  assign mem_hit  = paddr < xlen'(imem_depth * 4);
  assign ctrl_hit = paddr == ctrl_addr;

  // First access cycle, before the wait state ends.
  assign first_cycle = psel & penable & ~pready;

  // ******************************
  // RAM port A.
  // ******************************
  assign ena   = first_cycle & mem_hit;
  assign wea   = pwrite ? pstrb : '0;
  assign addra = paddr[imem_aw+1:2];
  assign dina  = pwdata;

  // RAM data is registered by the time pready is high.
  always_comb begin
    if (mem_hit) begin
      prdata = douta;
    end else if (ctrl_hit) begin
      prdata = {{(xlen-1){1'b0}}, run};
    end else begin
      prdata = '0;
    end
  end

  // ******************************
  // Handshake and run register.
  // ******************************
  always_ff @(posedge clkb) begin
    if (rstb) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      run     <= 1'b0;
    end else begin
      pready  <= first_cycle;
      pslverr <= first_cycle & ~(mem_hit | ctrl_hit);
      if (first_cycle && ctrl_hit && pwrite && pstrb[0]) begin
        run <= pwdata[0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire                        clkb,
  input  wire                        rstb,

  input  wire                        run,

  input  wire                        stall,
  input  wire                        redirect_valid,
  input  wire [fetch_pkg::xlen-1:0]  redirect_pc,

  output wire [fetch_pkg::xlen-1:0]  pc,
  output wire                        enb,
  input  wire [fetch_pkg::xlen-1:0]  instruction,

  output wire                        fetch_valid,
  output wire [fetch_pkg::xlen-1:0]  fetch_pc,
  output wire [fetch_pkg::xlen-1:0]  fetch_instr
);

  import fetch_pkg::*;

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] tag_q;
  logic            inflight_q;
  logic            accept;
  logic            issue;

  // ******************************
  // Issue decision.
  // ******************************
  assign accept = inflight_q & ~stall;

  // Slot must be empty or leaving this cycle.
  assign issue = run & ~redirect_valid & (~inflight_q | ~stall);

  assign pc  = pc_q;
  assign enb = issue;

  // ******************************
  // Sequencer state.
  // ******************************
  always_ff @(posedge clkb) begin
    if (rstb) begin
      pc_q       <= boot_pc;
      inflight_q <= 1'b0;
    end else if (redirect_valid) begin
      // Drop the word in flight.
      pc_q       <= redirect_pc;
      inflight_q <= 1'b0;
    end else if (issue) begin
      pc_q       <= pc_q + 32'd4;
      inflight_q <= 1'b1;
    end else if (accept) begin
      inflight_q <= 1'b0;
    end
  end

  // Address tag of the returning word.
  always_ff @(posedge clkb) begin
    if (issue) begin
      tag_q <= pc_q;
    end
  end

  assign fetch_valid = inflight_q;
  assign fetch_pc    = tag_q;
  // RAM output register holds while enb is low.
  assign fetch_instr = instruction;

endmodule

`default_nettype wire

// ==== imem/ins_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ins_mem (
  input  wire                          clkb,
  input  wire                          rstb,

  input  wire [fetch_pkg::xlen-1:0]    pc,
  input  wire                          enb,
  output wire [fetch_pkg::xlen-1:0]    instruction,

  input  wire                          ena,
  input  wire [fetch_pkg::strb_w-1:0]  wea,
  input  wire [fetch_pkg::imem_aw-1:0] addra,
  input  wire [fetch_pkg::xlen-1:0]    dina,
  output wire [fetch_pkg::xlen-1:0]    douta
);

  import fetch_pkg::*;

  wire [xlen-1:0] doutb;

  // Core sees a NOP until reset lifts.
  assign instruction = rstb ? nop_instr : doutb;

  bram_ins #(
    .depth_words(imem_depth)
  ) bram0 (
    .clkb  (clkb),
    .ena   (ena),
    .wea   (wea),
    .addra (addra),
    .dina  (dina),
    .douta (douta),
    .enb   (enb),
    .addrb (pc[imem_aw+1:2]),
    .doutb (doutb)
  );

endmodule

`default_nettype wire

// ==== imem/bram_ins.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram_ins #(
  parameter int depth_words = fetch_pkg::imem_depth
) (
  input  wire                          clkb,

  input  wire                          ena,
  input  wire [fetch_pkg::strb_w-1:0]  wea,
  input  wire [fetch_pkg::imem_aw-1:0] addra,
  input  wire [fetch_pkg::xlen-1:0]    dina,
  output logic [fetch_pkg::xlen-1:0]   douta,

  input  wire                          enb,
  input  wire [fetch_pkg::imem_aw-1:0] addrb,
  output logic [fetch_pkg::xlen-1:0]   doutb
);

  import fetch_pkg::*;

  logic [xlen-1:0] mem [0:depth_words-1];
  logic [xlen-1:0] merged_a;

  // ******************************
  // Port A, byte lanes.
  // ******************************
  // Current word with the strobed lanes replaced.
  always_comb begin
    merged_a = mem[addra];
    for (int i = 0; i < strb_w; i++) begin
      if (wea[i]) begin
        merged_a[8*i +: 8] = dina[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clkb) begin
    if (ena) begin
      if (|wea) begin
        mem[addra] <= merged_a;
      end
      // Write returns the merged word.
      douta <= merged_a;
    end
  end

  // ******************************
  // Port B, read only.
  // ******************************
  // Nonblocking read sees the old word on a collision.
  always_ff @(posedge clkb) begin
    if (enb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

`default_nettype wire

// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // ******************************
  // Word and bus widths.
  // ******************************
  localparam int xlen   = 32;
  localparam int strb_w = xlen / 8;

  // ******************************
  // Instruction memory geometry.
  // ******************************
  // 4 KB of program space.
  localparam int imem_depth = 1024;
  localparam int imem_aw    = $clog2(imem_depth);

  // ******************************
  // Fetch constants.
  // ******************************
  // addi x0, x0, 0.
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;
  localparam logic [xlen-1:0] boot_pc   = 32'h0000_0000;

  // Run control register, bit 0.
  localparam logic [xlen-1:0] ctrl_addr = 32'h0000_8000;

endpackage

`default_nettype wire
